// File: src.f
+incdir+include
rtl/rx_pkg.sv
rtl/rx_word_demux.sv
rtl/frame_aligner.sv
rtl/frame_decoder.sv
rtl/rx_uplink.sv
rtl/sp3_dual_rx_top.sv
test/sp3_dual_rx_tb.sv

// File: include/rx_tb_util.svh
// Testbench helpers that build frames, compute the checksum and serialize channel bit streams

`ifndef RX_TB_UTIL_SVH
`define RX_TB_UTIL_SVH

bit stream_a[$];  // Channel A bits still to send, MSB first
bit stream_b[$];  // Channel B bits still to send

////////////////////////////////////////
// Frame construction
////////////////////////////////////////

// XOR of the fifteen bytes above the checksum byte
function automatic logic [rx_pkg::CHK_W-1:0] checksum_of(input logic [rx_pkg::FRAME_W-1:0] f);
   logic [rx_pkg::CHK_W-1:0] acc;
   acc = '0;
   for (int i = 0; i < 15; i++) begin
      acc = acc ^ f[rx_pkg::FRAME_W-1 - 8*i -: 8]; // Walk down from the header byte
   end
   return acc;
endfunction

function automatic logic [rx_pkg::FRAME_W-1:0] build_frame(
   input logic [1:0]               ic,
   input logic [1:0]               ec,
   input logic [rx_pkg::USER_W-1:0] user,
   input logic                     bad_chk,  // Flip the checksum byte
   input logic                     bad_hdr   // Replace the header with its inverse
);
   logic [rx_pkg::FRAME_W-1:0] f;
   f      = {rx_pkg::HDR_PATTERN, ic, ec, user, 8'h00};
   f[7:0] = checksum_of(f);
   if (bad_chk) begin
      f[7:0] = ~f[7:0];
   end
   if (bad_hdr) begin
      f[rx_pkg::FRAME_W-1 -: 2] = ~rx_pkg::HDR_PATTERN; // Sum left as computed
   end
   return f;
endfunction

// Random good frame, user[15:8] kept at zero so it never looks like a table row
function automatic logic [rx_pkg::FRAME_W-1:0] filler_frame();
   logic [rx_pkg::FRAME_W-1:0] r;
   logic [rx_pkg::USER_W-1:0]  user;
   r          = {$urandom, $urandom, $urandom, $urandom};
   user       = r[rx_pkg::USER_W-1:0];
   user[15:8] = 8'h00;
   return build_frame(r[125:124], r[123:122], user, 1'b0, 1'b0);
endfunction

////////////////////////////////////////
// Serial streams
////////////////////////////////////////

function automatic void push_frame(input logic ch, input logic [rx_pkg::FRAME_W-1:0] f);
   for (int i = rx_pkg::FRAME_W-1; i >= 0; i--) begin
      if (ch) stream_b.push_back(f[i]);
      else    stream_a.push_back(f[i]);
   end
endfunction

// Leading junk bits that set the channel's initial bit offset
function automatic void push_random_bits(input logic ch, input int n);
   bit b;
   for (int i = 0; i < n; i++) begin
      b = ($urandom % 2) != 0;
      if (ch) stream_b.push_back(b);
      else    stream_a.push_back(b);
   end
endfunction

// Next channel word without consuming it, topped up with filler when short
function automatic logic [rx_pkg::WORD_W-1:0] peek_word(input logic ch);
   logic [rx_pkg::WORD_W-1:0] w;
   w = '0;
   while ((ch ? stream_b.size() : stream_a.size()) < rx_pkg::WORD_W) begin
      push_frame(ch, filler_frame());
   end
   for (int i = 0; i < rx_pkg::WORD_W; i++) begin
      w = {w[rx_pkg::WORD_W-2:0], (ch ? stream_b[i] : stream_a[i])};
   end
   return w;
endfunction

function automatic void drop_word(input logic ch);
   for (int i = 0; i < rx_pkg::WORD_W; i++) begin
      if (ch) void'(stream_b.pop_front());
      else    void'(stream_a.pop_front());
   end
endfunction

function automatic void clear_streams();
   stream_a.delete();
   stream_b.delete();
endfunction

`endif

// File: test/sp3_dual_rx_tb.sv
// Dual receiver testbench that streams table frames on both channels and checks each decoded frame

`timescale 1ns/100ps

module sp3_dual_rx_tb;

   localparam int         ROWS    = 12;
   localparam int         TIMEOUT = 2000;   // Cycles allowed for any wait
   localparam int         PRE_LEN = 16;     // Filler frames ahead of each pass
   localparam int         OFF_A   = 13;     // Initial bit offsets
   localparam int         OFF_B   = 5;
   localparam logic [7:0] ROW_TAG = 8'h5A;  // user[15:8] of every table frame

   logic                      MGT_RXCLK;
   logic                      arst_n_i;
   logic [rx_pkg::WORD_W-1:0] rx_word_i;
   logic                      rx_polarity_i;
   logic                      uplink_rst_i;
   logic [1:0]                ic_a_o;
   logic [1:0]                ec_a_o;
   logic [rx_pkg::USER_W-1:0] user_a_o;
   logic                      frame_valid_a_o;
   logic                      frame_err_a_o;
   logic                      rdy_a_o;
   logic [1:0]                ic_b_o;
   logic [1:0]                ec_b_o;
   logic [rx_pkg::USER_W-1:0] user_b_o;
   logic                      frame_valid_b_o;
   logic                      frame_err_b_o;
   logic                      rdy_b_o;

   logic dut_slot;   // Mirror of the demux slot with 0 for A
   logic invert;     // Line inversion of the sent bits
   logic timed_out;  // A wait ran out of cycles
   int   errors;

   // Stimulus table with one frame per row
   logic                      row_ch   [ROWS];  // 0 is A
   logic [1:0]                row_ic   [ROWS];
   logic [1:0]                row_ec   [ROWS];
   logic [rx_pkg::USER_W-1:0] row_user [ROWS];
   logic                      row_chk  [ROWS];  // Corrupt checksum so frame_err is expected
   logic                      row_hdr  [ROWS];  // Bad header so no frame is expected
   int                        exp_a[$];         // Row indices still due on A
   int                        exp_b[$];

   `include "rx_tb_util.svh"

   sp3_dual_rx_top sp3_dual_rx_top_inst (.*);

   initial begin
      MGT_RXCLK = 1'b0;
      forever #4 MGT_RXCLK = ~MGT_RXCLK;
   end

   task automatic check_equal(input string what, input logic [127:0] got,
                              input logic [127:0] want);
      if (got !== want) begin
         $display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, want);
         errors++;
      end
   endtask

   task automatic end_run();
      $display("Run finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   ////////////////////////////////////////
   // Stream driver
   ////////////////////////////////////////

   // Word is consumed only at an edge outside reset
   task automatic next_cycle();
      @(posedge MGT_RXCLK);
      if (!arst_n_i || uplink_rst_i) begin
         dut_slot = 1'b0;            // Demux phase cleared
      end else begin
         drop_word(dut_slot);
         dut_slot = ~dut_slot;
      end
      #1;
      rx_word_i = peek_word(dut_slot) ^ {rx_pkg::WORD_W{invert}};
   endtask

   task automatic wait_rdy_level(input logic ch, input logic level);
      int n;
      n = 0;
      while (!timed_out && ((ch ? rdy_b_o : rdy_a_o) !== level) && (n < TIMEOUT)) begin
         next_cycle();
         n++;
      end
      if (!timed_out && ((ch ? rdy_b_o : rdy_a_o) !== level)) begin
         $display("Timeout: rdy of channel %s did not go to %0b within %0d cycles",
                  ch ? "B" : "A", level, TIMEOUT);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   // Both channels share one lock budget
   task automatic wait_both_rdy();
      int n;
      n = 0;
      while (!timed_out && ((rdy_a_o !== 1'b1) || (rdy_b_o !== 1'b1)) && (n < TIMEOUT)) begin
         next_cycle();
         n++;
      end
      if (!timed_out && ((rdy_a_o !== 1'b1) || (rdy_b_o !== 1'b1))) begin
         $display("Timeout: channels not both ready within %0d cycles, A is %0b and B is %0b",
                  TIMEOUT, rdy_a_o, rdy_b_o);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_expected_frames();
      int n;
      n = 0;
      while (!timed_out && (exp_a.size() + exp_b.size() > 0) && (n < TIMEOUT)) begin
         next_cycle();
         n++;
      end
      if (!timed_out && (exp_a.size() + exp_b.size() > 0)) begin
         $display("Timeout: %0d table frames on A and %0d on B never arrived",
                  exp_a.size(), exp_b.size());
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic set_row(input int i, input logic ch, input logic [1:0] ic,
                          input logic [1:0] ec, input logic [31:0] seed,
                          input logic bad_chk, input logic bad_hdr);
      row_ch[i]   = ch;
      row_ic[i]   = ic;
      row_ec[i]   = ec;
      row_user[i] = {{3{seed}}, seed[1:0], ROW_TAG, i[7:0]}; // Low byte is the index
      row_chk[i]  = bad_chk;
      row_hdr[i]  = bad_hdr;
   endtask

   task automatic load_table();
      set_row(0,  1'b0, 2'd1, 2'd2, 32'h1234_5678, 1'b0, 1'b0);
      set_row(1,  1'b1, 2'd3, 2'd0, 32'h9ABC_DEF0, 1'b0, 1'b0);
      set_row(2,  1'b0, 2'd0, 2'd3, 32'h0F0F_3C3C, 1'b1, 1'b0);  // Corrupt sum
      set_row(3,  1'b1, 2'd2, 2'd1, 32'hDEAD_BEEF, 1'b0, 1'b0);
      set_row(4,  1'b0, 2'd1, 2'd1, 32'h0000_0001, 1'b0, 1'b1);  // Four bad headers on A
      set_row(5,  1'b0, 2'd2, 2'd0, 32'h0000_0002, 1'b0, 1'b1);
      set_row(6,  1'b0, 2'd3, 2'd1, 32'h0000_0003, 1'b0, 1'b1);
      set_row(7,  1'b0, 2'd0, 2'd2, 32'h0000_0004, 1'b0, 1'b1);
      set_row(8,  1'b0, 2'd2, 2'd2, 32'hA5A5_5A5A, 1'b0, 1'b0);
      set_row(9,  1'b1, 2'd1, 2'd3, 32'h7777_8888, 1'b1, 1'b0);  // Corrupt sum
      set_row(10, 1'b1, 2'd0, 2'd0, 32'hFFFF_0000, 1'b0, 1'b0);
      set_row(11, 1'b0, 2'd3, 2'd3, 32'h1357_9BDF, 1'b0, 1'b0);
   endtask

   // Offset bits then the lock preamble on both channels
   task automatic prime_streams();
      push_random_bits(1'b0, OFF_A);
      push_random_bits(1'b1, OFF_B);
      for (int k = 0; k < PRE_LEN; k++) begin
         push_frame(1'b0, filler_frame());
         push_frame(1'b1, filler_frame());
      end
   endtask

   task automatic send_table();
      for (int i = 0; i < ROWS; i++) begin
         push_frame(row_ch[i], build_frame(row_ic[i], row_ec[i], row_user[i],
                                           row_chk[i], row_hdr[i]));
         if (!row_hdr[i]) begin
            if (row_ch[i]) exp_b.push_back(i);
            else           exp_a.push_back(i);
         end else if ((i == ROWS-1) || !row_hdr[i+1]) begin
            wait_rdy_level(row_ch[i], 1'b0);  // End of a bad header run drops lock
            wait_rdy_level(row_ch[i], 1'b1);  // Filler lets it relock
         end
      end
   endtask

   task automatic run_pass();
      wait_both_rdy();
      send_table();
      wait_expected_frames();
   endtask

   ////////////////////////////////////////
   // Frame monitor
   ////////////////////////////////////////

   task automatic check_frame(input logic ch, input logic [1:0] ic, input logic [1:0] ec,
                              input logic [rx_pkg::USER_W-1:0] user, input logic err);
      int idx;
      int want;
      idx  = user[7:0];
      want = -1;
      if (user[15:8] !== ROW_TAG) begin
         check_equal("frame_err on a filler frame", err, 1'b0);
      end else if ((idx >= ROWS) || (row_ch[idx] !== ch)) begin
         $display("Frame with row index %0d arrived on the wrong channel", idx);
         errors++;
      end else if (!row_hdr[idx]) begin       // Bad header rows may still decode
         if (!ch && (exp_a.size() > 0)) want = exp_a.pop_front();
         if (ch && (exp_b.size() > 0))  want = exp_b.pop_front();
         check_equal("row index in table order", idx, want);
         check_equal("ic", ic, row_ic[idx]);
         check_equal("ec", ec, row_ec[idx]);
         check_equal("user", user, row_user[idx]);
         check_equal("frame_err", err, row_chk[idx]);
      end
   endtask

   initial begin
      forever begin
         @(negedge MGT_RXCLK);  // Outputs settled mid cycle
         if (frame_valid_a_o === 1'b1) check_frame(1'b0, ic_a_o, ec_a_o, user_a_o, frame_err_a_o);
         if (frame_valid_b_o === 1'b1) check_frame(1'b1, ic_b_o, ec_b_o, user_b_o, frame_err_b_o);
      end
   end

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      arst_n_i      = 1'b0;
      rx_word_i     = '0;
      rx_polarity_i = 1'b0;
      uplink_rst_i  = 1'b0;
      dut_slot      = 1'b0;
      invert        = 1'b0;
      timed_out     = 1'b0;
      errors        = 0;
      void'($urandom(84378));
      load_table();
      prime_streams();
      repeat (3) next_cycle();
      arst_n_i = 1'b1;
      check_equal("rdy_a_o after reset", rdy_a_o, 1'b0);
      check_equal("rdy_b_o after reset", rdy_b_o, 1'b0);
      check_equal("frame_valid_a_o after reset", frame_valid_a_o, 1'b0);
      check_equal("frame_valid_b_o after reset", frame_valid_b_o, 1'b0);
      check_equal("frame_err_a_o after reset", frame_err_a_o, 1'b0);
      check_equal("frame_err_b_o after reset", frame_err_b_o, 1'b0);
      run_pass();
      // Soft reset then the same traffic inverted on the line
      uplink_rst_i = 1'b1;
      next_cycle();
      clear_streams();
      invert        = 1'b1;
      rx_polarity_i = 1'b1;
      prime_streams();
      next_cycle();
      uplink_rst_i = 1'b0;
      check_equal("rdy_a_o after soft reset", rdy_a_o, 1'b0);
      check_equal("rdy_b_o after soft reset", rdy_b_o, 1'b0);
      run_pass();
      end_run();
   end

endmodule

// File: rtl/sp3_dual_rx_top.sv
// Dual channel receiver top, word demux feeding two independent uplink channels

`timescale 1ns/100ps

module sp3_dual_rx_top (
   input  logic                     MGT_RXCLK,
   input  logic                     arst_n_i,
   input  logic [rx_pkg::WORD_W-1:0] rx_word_i,     // Interleaved A and B words
   input  logic                     rx_polarity_i, // Invert received bits
   input  logic                     uplink_rst_i,  // Soft reset of both channels
   // Channel A
   output logic [1:0]               ic_a_o,
   output logic [1:0]               ec_a_o,
   output logic [rx_pkg::USER_W-1:0] user_a_o,
   output logic                     frame_valid_a_o,
   output logic                     frame_err_a_o,
   output logic                     rdy_a_o,
   // Channel B
   output logic [1:0]               ic_b_o,
   output logic [1:0]               ec_b_o,
   output logic [rx_pkg::USER_W-1:0] user_b_o,
   output logic                     frame_valid_b_o,
   output logic                     frame_err_b_o,
   output logic                     rdy_b_o
);

   logic [rx_pkg::WORD_W-1:0] word_a;       // De-interleaved A words
   logic [rx_pkg::WORD_W-1:0] word_b;       // De-interleaved B words
   logic                      word_a_valid;
   logic                      word_b_valid;
   logic                      bitslip_a;    // Slip requests back to the demux
   logic                      bitslip_b;

   ////////////////////////////////////////
   // Demux
   ////////////////////////////////////////

   rx_word_demux rx_word_demux_inst (
      .MGT_RXCLK      (MGT_RXCLK),
      .arst_n_i       (arst_n_i),
      .rx_word_i      (rx_word_i),
      .rx_polarity_i  (rx_polarity_i),
      .soft_rst_i     (uplink_rst_i),
      .bitslip_a_i    (bitslip_a),
      .bitslip_b_i    (bitslip_b),
      .word_a_o       (word_a),
      .word_a_valid_o (word_a_valid),
      .word_b_o       (word_b),
      .word_b_valid_o (word_b_valid)
   );

   ////////////////////////////////////////
   // Uplink channels
   ////////////////////////////////////////

   rx_uplink uplink_a (
      .MGT_RXCLK     (MGT_RXCLK),
      .arst_n_i      (arst_n_i),
      .soft_rst_i    (uplink_rst_i),
      .word_i        (word_a),
      .word_valid_i  (word_a_valid),
      .bitslip_o     (bitslip_a),
      .ic_o          (ic_a_o),
      .ec_o          (ec_a_o),
      .user_o        (user_a_o),
      .frame_valid_o (frame_valid_a_o),
      .frame_err_o   (frame_err_a_o),
      .rdy_o         (rdy_a_o)
   );

   rx_uplink uplink_b (
      .MGT_RXCLK     (MGT_RXCLK),
      .arst_n_i      (arst_n_i),
      .soft_rst_i    (uplink_rst_i),
      .word_i        (word_b),
      .word_valid_i  (word_b_valid),
      .bitslip_o     (bitslip_b),
      .ic_o          (ic_b_o),
      .ec_o          (ec_b_o),
      .user_o        (user_b_o),
      .frame_valid_o (frame_valid_b_o),
      .frame_err_o   (frame_err_b_o),
      .rdy_o         (rdy_b_o)
   );

endmodule

// File: rtl/rx_uplink.sv
// Receive pipeline of one channel, frame aligner followed by frame decoder

`timescale 1ns/100ps

module rx_uplink (
   input  logic                     MGT_RXCLK,
   input  logic                     arst_n_i,
   input  logic                     soft_rst_i,    // Uplink soft reset
   input  logic [rx_pkg::WORD_W-1:0] word_i,        // Channel word from the demux
   input  logic                     word_valid_i,
   output logic                     bitslip_o,     // Back to the demux
   output logic [1:0]               ic_o,
   output logic [1:0]               ec_o,
   output logic [rx_pkg::USER_W-1:0] user_o,
   output logic                     frame_valid_o,
   output logic                     frame_err_o,
   output logic                     rdy_o          // Channel locked
);

   logic [rx_pkg::WORD_W-1:0] aligned_word;
   logic                      word_valid;
   logic                      frame_start;
   logic                      locked;

   // Header search, lock and slip requests
   frame_aligner frame_aligner_inst (
      .MGT_RXCLK     (MGT_RXCLK),
      .arst_n_i      (arst_n_i),
      .soft_rst_i    (soft_rst_i),
      .word_i        (word_i),
      .word_valid_i  (word_valid_i),
      .bitslip_o     (bitslip_o),
      .word_o        (aligned_word),
      .word_valid_o  (word_valid),
      .frame_start_o (frame_start),
      .locked_o      (locked)
   );

   // Frame assembly and checksum
   frame_decoder frame_decoder_inst (
      .MGT_RXCLK     (MGT_RXCLK),
      .arst_n_i      (arst_n_i),
      .word_i        (aligned_word),
      .word_valid_i  (word_valid),
      .frame_start_i (frame_start),
      .locked_i      (locked),
      .ic_o          (ic_o),
      .ec_o          (ec_o),
      .user_o        (user_o),
      .frame_valid_o (frame_valid_o),
      .frame_err_o   (frame_err_o)
   );

   assign rdy_o = locked; // Ready as soon as the aligner holds lock

endmodule

// File: rtl/frame_decoder.sv
// Rebuilds one channel's frames from aligned words, checks the checksum, splits the fields

`timescale 1ns/100ps

module frame_decoder (
   input  logic                     MGT_RXCLK,
   input  logic                     arst_n_i,
   input  logic [rx_pkg::WORD_W-1:0] word_i,        // Aligned word
   input  logic                     word_valid_i,
   input  logic                     frame_start_i, // Header word, restarts assembly
   input  logic                     locked_i,      // Frames dropped while low
   output logic [1:0]               ic_o,
   output logic [1:0]               ec_o,
   output logic [rx_pkg::USER_W-1:0] user_o,
   output logic                     frame_valid_o, // One cycle per frame
   output logic                     frame_err_o    // Checksum mismatch
);

   rx_pkg::frame_t frame_q;    // Assembled frame
   rx_pkg::frame_t frame_d;    // Frame including the incoming word
   logic [1:0]     wcnt;       // Words taken since the header
   logic           last_word;  // Incoming word completes a frame
   logic           chk_bad;

   // XOR of every byte above the checksum byte
   function automatic logic [rx_pkg::CHK_W-1:0] chk_fold(
      input logic [rx_pkg::FRAME_W-1:0] raw
   );
      logic [rx_pkg::CHK_W-1:0] acc;
      acc = '0;
      for (int b = 1; b < rx_pkg::FRAME_W / rx_pkg::CHK_W; b++) begin
         acc = acc ^ raw[b*rx_pkg::CHK_W +: rx_pkg::CHK_W];
      end
      return acc;
   endfunction

   always_comb begin
      frame_d.raw = {frame_q.raw[rx_pkg::FRAME_W-rx_pkg::WORD_W-1:0], word_i}; // Shift in
   end

   assign last_word = word_valid_i && !frame_start_i && (wcnt == rx_pkg::FRAME_WORDS - 1);
   assign chk_bad   = (chk_fold(frame_d.raw) != frame_d.f.chk);

   ////////////////////////////////////////
   // Word count and strobes
   ////////////////////////////////////////

   always_ff @(posedge MGT_RXCLK or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wcnt          <= 2'd0;
         frame_valid_o <= 1'b0;
         frame_err_o   <= 1'b0;
      end else begin
         if (frame_start_i) begin
            wcnt <= 2'd1;
         end else if (word_valid_i) begin
            wcnt <= wcnt + 2'd1;
         end
         frame_valid_o <= last_word && locked_i;            // 1 cycle after word four
         frame_err_o   <= last_word && locked_i && chk_bad;
      end
   end

   always_ff @(posedge MGT_RXCLK) begin
      if (word_valid_i) begin
         frame_q <= frame_d;
      end
   end

   // Fields hold until the next word shifts in
   assign ic_o   = frame_q.f.ic;
   assign ec_o   = frame_q.f.ec;
   assign user_o = frame_q.f.user;

endmodule

// File: rtl/frame_aligner.sv
// Finds the frame boundary of one channel from its header, and locks with hysteresis

`timescale 1ns/100ps

module frame_aligner (
   input  logic                     MGT_RXCLK,
   input  logic                     arst_n_i,
   input  logic                     soft_rst_i,    // Drops lock and slip state
   input  logic [rx_pkg::WORD_W-1:0] word_i,        // From the demux
   input  logic                     word_valid_i,
   output logic                     bitslip_o,     // One cycle, one bit later
   output logic [rx_pkg::WORD_W-1:0] word_o,        // Registered copy of word_i
   output logic                     word_valid_o,
   output logic                     frame_start_o, // Word holding the header
   output logic                     locked_o
);

   logic [1:0] state;     // FSM state
   logic [1:0] cnt;       // Word in frame, 0 is the header slot
   logic [1:0] wait_cnt;  // Words ignored so far after a slip
   logic [3:0] good_cnt;  // Good headers in a row
   logic [2:0] bad_cnt;   // Bad headers in a row while locked
   logic [4:0] slip_cnt;  // Slips since the last skip
   logic       hdr_slot;  // Incoming word sits in the header slot
   logic       hdr_ok;    // Its top bits match the pattern
   logic       retry;     // Try the next candidate boundary
   logic       skip;      // Hold the word counter for one word

   assign hdr_slot = word_valid_i && (cnt == 2'd0);
   assign hdr_ok   = (word_i[rx_pkg::WORD_W-1 -: 2] == rx_pkg::HDR_PATTERN);
   assign retry    = hdr_slot && !hdr_ok &&
                     ((state == rx_pkg::ST_HUNT) || (state == rx_pkg::ST_CONFIRM));
   assign skip     = retry && (slip_cnt == rx_pkg::SLIP_MAX); // Offsets used up
   assign locked_o = (state == rx_pkg::ST_LOCKED);

   ////////////////////////////////////////
   // Lock FSM
   ////////////////////////////////////////

   always_ff @(posedge MGT_RXCLK or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state         <= rx_pkg::ST_HUNT;
         cnt           <= 2'd0;
         wait_cnt      <= 2'd0;
         good_cnt      <= 4'd0;
         bad_cnt       <= 3'd0;
         slip_cnt      <= 5'd0;
         bitslip_o     <= 1'b0;
         word_valid_o  <= 1'b0;
         frame_start_o <= 1'b0;
      end else if (soft_rst_i) begin
         state         <= rx_pkg::ST_HUNT;
         cnt           <= 2'd0;
         wait_cnt      <= 2'd0;
         good_cnt      <= 4'd0;
         bad_cnt       <= 3'd0;
         slip_cnt      <= 5'd0;   // Demux offset goes back to 0 as well
         bitslip_o     <= 1'b0;
         word_valid_o  <= 1'b0;
         frame_start_o <= 1'b0;
      end else begin
         bitslip_o     <= 1'b0;
         word_valid_o  <= word_valid_i;
         frame_start_o <= hdr_slot;
         if (word_valid_i && !skip) begin
            cnt <= cnt + 2'd1;  // A skip moves the header slot one word later
         end
         case (state)
            rx_pkg::ST_HUNT: begin
               if (hdr_slot && hdr_ok) begin
                  state    <= rx_pkg::ST_CONFIRM;
                  good_cnt <= 4'd1;
               end
            end
            rx_pkg::ST_WAIT: begin
               if (word_valid_i) begin
                  if (wait_cnt == rx_pkg::SLIP_WAIT - 1) begin
                     state    <= rx_pkg::ST_HUNT;
                     wait_cnt <= 2'd0;
                  end else begin
                     wait_cnt <= wait_cnt + 2'd1;
                  end
               end
            end
            rx_pkg::ST_CONFIRM: begin
               if (hdr_slot && hdr_ok) begin
                  if (good_cnt == rx_pkg::LOCK_GOOD - 1) begin
                     state   <= rx_pkg::ST_LOCKED;
                     bad_cnt <= 3'd0;
                  end else begin
                     good_cnt <= good_cnt + 4'd1;
                  end
               end
            end
            default: begin  // Locked
               if (hdr_slot && hdr_ok) begin
                  bad_cnt <= 3'd0;
               end else if (hdr_slot) begin
                  if (bad_cnt == rx_pkg::UNLOCK_BAD - 1) begin
                     state   <= rx_pkg::ST_HUNT; // Next header slot is checked afresh
                     bad_cnt <= 3'd0;
                  end else begin
                     bad_cnt <= bad_cnt + 3'd1;
                  end
               end
            end
         endcase
         // Bad header before lock: slip one bit, or skip a word after a full sweep
         if (retry) begin
            state    <= rx_pkg::ST_WAIT;
            wait_cnt <= 2'd0;
            good_cnt <= 4'd0;
            if (skip) begin
               slip_cnt <= 5'd0;
            end else begin
               bitslip_o <= 1'b1;
               slip_cnt  <= slip_cnt + 5'd1;
            end
         end
      end
   end

   always_ff @(posedge MGT_RXCLK) begin
      if (word_valid_i) begin
         word_o <= word_i;
      end
   end

endmodule

// File: rtl/rx_word_demux.sv
// Splits the interleaved receive words into channels A and B, with polarity and bit slip

`timescale 1ns/100ps

module rx_word_demux (
   input  logic                     MGT_RXCLK,
   input  logic                     arst_n_i,
   input  logic [rx_pkg::WORD_W-1:0] rx_word_i,      // Interleaved, A in even slots
   input  logic                     rx_polarity_i,  // Invert every received bit
   input  logic                     soft_rst_i,     // Clears slot phase and offsets
   input  logic                     bitslip_a_i,    // Move A boundary one bit later
   input  logic                     bitslip_b_i,    // Move B boundary one bit later
   output logic [rx_pkg::WORD_W-1:0] word_a_o,
   output logic                     word_a_valid_o,
   output logic [rx_pkg::WORD_W-1:0] word_b_o,
   output logic                     word_b_valid_o
);

   logic [rx_pkg::WORD_W-1:0]   word_in;      // Polarity corrected input
   logic                        slot;         // 0 loads A, 1 loads B
   logic [1:0]                  slip;         // Slip requests, bit 0 is A
   logic [rx_pkg::WORD_W-1:0]   prev_q  [2];  // Last word seen on each channel
   logic [4:0]                  off_q   [2];  // Current bit offset per channel
   logic [4:0]                  off_eff [2];  // Offset including a slip this cycle
   logic [2*rx_pkg::WORD_W-1:0] cat     [2];  // Previous word followed by new one
   logic [rx_pkg::WORD_W-1:0]   sel     [2];  // Realigned channel word

   assign word_in = rx_word_i ^ {rx_pkg::WORD_W{rx_polarity_i}};
   assign slip    = {bitslip_b_i, bitslip_a_i};

   ////////////////////////////////////////
   // Barrel shifter, one per channel
   ////////////////////////////////////////

   // Offset 0 gives the previous word unchanged, each step takes one bit later
   always_comb begin
      for (int ch = 0; ch < 2; ch++) begin
         off_eff[ch] = off_q[ch] + {4'd0, slip[ch]}; // 31 wraps to 0
         cat[ch]     = {prev_q[ch], word_in};
         sel[ch]     = cat[ch][2*rx_pkg::WORD_W-1 - off_eff[ch] -: rx_pkg::WORD_W];
      end
   end

   ////////////////////////////////////////
   // Slot phase and offsets
   ////////////////////////////////////////

   always_ff @(posedge MGT_RXCLK or negedge arst_n_i) begin
      if (!arst_n_i) begin
         slot           <= 1'b0;  // First word after reset is A
         word_a_valid_o <= 1'b0;
         word_b_valid_o <= 1'b0;
         for (int ch = 0; ch < 2; ch++) begin
            off_q[ch] <= '0;
         end
      end else if (soft_rst_i) begin
         slot           <= 1'b0;
         word_a_valid_o <= 1'b0;
         word_b_valid_o <= 1'b0;
         for (int ch = 0; ch < 2; ch++) begin
            off_q[ch] <= '0;
         end
      end else begin
         slot           <= ~slot;
         word_a_valid_o <= ~slot; // Strobe one cycle after the A input word
         word_b_valid_o <= slot;
         for (int ch = 0; ch < 2; ch++) begin
            if (slip[ch]) begin
               off_q[ch] <= off_eff[ch];
            end
         end
      end
   end

   // Channel data, loaded on its own slot only
   always_ff @(posedge MGT_RXCLK) begin
      if (!slot) begin
         prev_q[0] <= word_in;
         word_a_o  <= sel[0];
      end else begin
         prev_q[1] <= word_in;
         word_b_o  <= sel[1];
      end
   end

endmodule

// File: rtl/rx_pkg.sv
// Shared widths, header pattern, lock thresholds and frame layout for the dual receiver

package rx_pkg;

   ////////////////////////////////////////
   // Word and frame geometry
   ////////////////////////////////////////

   localparam int WORD_W      = 32;  // One transceiver word
   localparam int FRAME_WORDS = 4;   // Words per frame
   localparam int FRAME_W     = 128; // Frame width in bits
   localparam int USER_W      = 114; // User payload
   localparam int CHK_W       = 8;   // XOR checksum byte

   // Frame header, found in bits 127:126
   localparam logic [1:0] HDR_PATTERN = 2'b10;

   ////////////////////////////////////////
   // Frame alignment
   ////////////////////////////////////////

   localparam int LOCK_GOOD  = 8;  // Good headers in a row to lock
   localparam int UNLOCK_BAD = 4;  // Bad headers in a row to drop lock
   localparam int SLIP_WAIT  = 2;  // Channel words ignored after a slip or skip
   localparam int SLIP_MAX   = 31; // Last bit offset before a word skip

   // Aligner FSM codes
   localparam logic [1:0] ST_HUNT    = 2'd0; // Checking one candidate boundary
   localparam logic [1:0] ST_WAIT    = 2'd1; // Letting a slip settle
   localparam logic [1:0] ST_CONFIRM = 2'd2; // Counting good headers
   localparam logic [1:0] ST_LOCKED  = 2'd3; // Frames are trusted

   // One received frame, seen as raw bits or as its fields
   typedef union packed {
      logic [FRAME_W-1:0] raw;     // As shifted in, first word on top
      struct packed {
         logic [1:0]        hdr;   // Sync header
         logic [1:0]        ic;    // Internal control
         logic [1:0]        ec;    // External control
         logic [USER_W-1:0] user;  // User data
         logic [CHK_W-1:0]  chk;   // XOR of the fifteen bytes above
      } f;
   } frame_t;

endpackage
